//--- verilog/shf_settings.svh
// ========================================
// Word, address and count widths, queue
// depths and credit width of the engine
// ========================================
`ifndef SHF_SETTINGS_SVH
`define SHF_SETTINGS_SVH

// Data word
`define SHF_BYTES       4
`define SHF_DATA_W      32

// Job fields
`define SHF_ADDR_W      16
`define SHF_CNT_W       8
`define SHF_OFF_W       2

// Input queue in the buffer, also the read credit pool
`define SHF_IN_DEPTH    4
// Output queue in the consumer, also the push credit pool
`define SHF_OUT_DEPTH   2

// Wide enough for the larger of the two depths
`define SHF_CREDIT_W    3

`endif

//--- verilog/shf_pkg.sv
// ========================================
// Job struct, output word struct and the
// controller state enum
// ========================================
`include "shf_settings.svh"

package shf_pkg;

    // ========================================
    // Job descriptor
    // ========================================
    // 42 bits, in_addr in the top bits
    typedef struct packed {
        // First input word
        logic [`SHF_ADDR_W-1:0] in_addr;
        // First output word
        logic [`SHF_ADDR_W-1:0] out_addr;
        // Words per job, 1 to 255
        logic [`SHF_CNT_W-1:0]  num;
        // Byte shift into the stream
        logic [`SHF_OFF_W-1:0]  byte_off;
    } shf_job_t;

    // ========================================
    // Buffer to consumer word
    // ========================================
    typedef struct packed {
        logic [`SHF_DATA_W-1:0] data;
        // Set on the final word of a job
        logic                   last;
    } shf_out_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } shf_state_e;

endpackage

//--- verilog/shf_ctrl.sv
// ========================================
// Job acceptance and IDLE/RUN/DRAIN FSM
// ========================================
`timescale 1ns/1ps

module shf_ctrl import shf_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_valid,
    input  shf_job_t   cfg,
    input  logic       rd_done,
    input  logic       wr_done,
    output logic       cfg_ready,
    output logic       start,
    output shf_job_t   job
);

    shf_state_e state_q;
    shf_state_e state_d;
    shf_job_t   job_q;

    // Ready only between jobs
    assign cfg_ready = (state_q == IDLE);
    // One pulse per accepted job
    assign start     = cfg_valid && cfg_ready;
    assign job       = job_q;

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start) state_d = RUN;
            // All reads issued
            RUN:     if (rd_done) state_d = DRAIN;
            // Final write taken
            DRAIN:   if (wr_done) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Job held stable until the next acceptance
    always_ff @(posedge clk) begin
        if (start) begin
            job_q <= cfg;
        end
    end

endmodule

//--- verilog/shf_rd_gen.sv
// ========================================
// Read generator, issues one address per
// held input credit
// ========================================
`timescale 1ns/1ps
`include "shf_settings.svh"

module shf_rd_gen import shf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  shf_job_t               job,
    input  logic                   rd_req_ready,
    input  logic                   in_credit,
    output logic                   rd_req_valid,
    output logic [`SHF_ADDR_W-1:0] rd_addr,
    output logic                   rd_done
);

    localparam int ADDR_W = `SHF_ADDR_W;
    localparam int CW     = `SHF_CREDIT_W;

    // Words left to request
    logic                  busy;
    // Requests accepted so far
    logic [`SHF_CNT_W-1:0] issued;
    // Free slots in the buffer's input queue
    logic [CW-1:0]         cred;
    logic                  issue;

    // ========================================
    // Request port
    // ========================================
    assign rd_req_valid = busy && (cred != '0);
    assign issue        = rd_req_valid && rd_req_ready;
    // Address stays put while the request waits
    assign rd_addr      = job.in_addr + ADDR_W'(issued);
    // Handshake of request num-1
    assign rd_done      = issue && (issued == job.num - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            issued <= '0;
        end else if (start) begin
            busy   <= 1'b1;
            issued <= '0;
        end else if (issue) begin
            issued <= issued + 1'b1;
            if (rd_done) begin
                busy <= 1'b0;
            end
        end
    end

    // ========================================
    // Credit counter
    // ========================================
    // Full pool on each job, one back per buffer pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cred <= '0;
        end else if (start) begin
            cred <= CW'(`SHF_IN_DEPTH);
        end else begin
            case ({in_credit, issue})
                2'b10:   cred <= cred + 1'b1;
                2'b01:   cred <= cred - 1'b1;
                default: cred <= cred;
            endcase
        end
    end

endmodule

//--- verilog/shf_align_buf.sv
// ========================================
// Alignment buffer with input queue, two
// word window and byte shifter
// ========================================
`timescale 1ns/1ps
`include "shf_settings.svh"

module shf_align_buf import shf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  shf_job_t               job,
    input  logic                   rd_data_valid,
    input  logic [`SHF_DATA_W-1:0] rd_data,
    input  logic                   out_credit,
    output logic                   in_credit,
    output logic                   out_push,
    output shf_out_t               out_word
);

    localparam int DEPTH = `SHF_IN_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int DW    = `SHF_DATA_W;
    localparam int BW    = DW / `SHF_BYTES;
    localparam int CW    = `SHF_CREDIT_W;

    // Input queue
    logic [DW-1:0]         q_mem [DEPTH];
    logic [PTR_W-1:0]      q_wr_ptr;
    logic [PTR_W-1:0]      q_rd_ptr;
    logic [CW-1:0]         q_cnt;
    logic                  pop;

    // Window, win0 is stream word j and win1 word j+1
    logic [DW-1:0]         win0;
    logic [DW-1:0]         win1;
    logic                  win0_vld;
    logic                  win1_vld;
    logic                  ld0_w1;
    logic                  ld0_q;
    logic                  ld1_q;
    // Words moved from the queue into the window
    logic [`SHF_CNT_W-1:0] rx_cnt;
    logic                  is_last;
    logic                  fire;
    // Free slots in the consumer queue
    logic [CW-1:0]         cred;
    logic [2*DW-1:0]       pair;

    // ========================================
    // Input queue
    // ========================================
    // Credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (rd_data_valid) begin
            q_mem[q_wr_ptr] <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
        end else begin
            if (rd_data_valid) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (pop) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            case ({rd_data_valid, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // ========================================
    // Window control
    // ========================================
    // Final word is alone in win0 once all words are in
    assign is_last = win0_vld && !win1_vld && (rx_cnt == job.num);
    assign fire    = win0_vld && (win1_vld || is_last) && (cred != '0);
    // Pop when a window slot is free after this cycle
    assign pop     = (q_cnt != '0) && (!win0_vld || !win1_vld || fire);

    // Shift on fire, queue head fills the first free slot
    assign ld0_w1  = fire && win1_vld;
    assign ld0_q   = pop && (fire ? !win1_vld : !win0_vld);
    assign ld1_q   = pop && (fire ? win1_vld : win0_vld);

    always_ff @(posedge clk) begin
        if (ld0_w1) begin
            win0 <= win1;
        end else if (ld0_q) begin
            win0 <= q_mem[q_rd_ptr];
        end
        if (ld1_q) begin
            win1 <= q_mem[q_rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win0_vld <= 1'b0;
            win1_vld <= 1'b0;
            rx_cnt   <= '0;
        end else begin
            if (ld0_w1 || ld0_q) begin
                win0_vld <= 1'b1;
            end else if (fire) begin
                win0_vld <= 1'b0;
            end
            if (ld1_q) begin
                win1_vld <= 1'b1;
            end else if (fire) begin
                win1_vld <= 1'b0;
            end
            if (start) begin
                rx_cnt <= '0;
            end else if (pop) begin
                rx_cnt <= rx_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Byte shifter and output credits
    // ========================================
    // Zero upper word past the end of the stream
    assign pair = {(is_last ? {DW{1'b0}} : win1), win0};

    always_comb begin
        for (int b = 0; b < `SHF_BYTES; b++) begin
            out_word.data[b*BW +: BW] = pair[(b + int'(job.byte_off))*BW +: BW];
        end
    end

    assign out_word.last = is_last;
    assign out_push      = fire;
    assign in_credit     = pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cred <= '0;
        end else if (start) begin
            cred <= CW'(`SHF_OUT_DEPTH);
        end else begin
            case ({out_credit, fire})
                2'b10:   cred <= cred + 1'b1;
                2'b01:   cred <= cred - 1'b1;
                default: cred <= cred;
            endcase
        end
    end

endmodule

//--- verilog/shf_wr_gen.sv
// ========================================
// Write generator with output queue and
// write address counter
// ========================================
`timescale 1ns/1ps
`include "shf_settings.svh"

module shf_wr_gen import shf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  shf_job_t               job,
    input  logic                   out_push,
    input  shf_out_t               out_word,
    input  logic                   wr_ready,
    output logic                   out_credit,
    output logic                   wr_valid,
    output logic [`SHF_ADDR_W-1:0] wr_addr,
    output logic [`SHF_DATA_W-1:0] wr_data,
    output logic                   wr_done
);

    localparam int DEPTH  = `SHF_OUT_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int ADDR_W = `SHF_ADDR_W;

    shf_out_t              q_mem [DEPTH];
    logic [PTR_W-1:0]      q_wr_ptr;
    logic [PTR_W-1:0]      q_rd_ptr;
    logic [`SHF_CREDIT_W-1:0] q_cnt;
    // Writes taken this job
    logic [`SHF_CNT_W-1:0] wr_cnt;
    logic                  wr_hs;

    // ========================================
    // Write port
    // ========================================
    assign wr_valid   = (q_cnt != '0);
    assign wr_data    = q_mem[q_rd_ptr].data;
    assign wr_addr    = job.out_addr + ADDR_W'(wr_cnt);
    assign wr_hs      = wr_valid && wr_ready;
    // Slot freed, credit back to the buffer
    assign out_credit = wr_hs;
    assign wr_done    = wr_hs && q_mem[q_rd_ptr].last;

    // Push only arrives with a credit, so no full check
    always_ff @(posedge clk) begin
        if (out_push) begin
            q_mem[q_wr_ptr] <= out_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
            wr_cnt   <= '0;
        end else begin
            if (out_push) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (wr_hs) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            case ({out_push, wr_hs})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            // Address offset restarts per job
            if (start) begin
                wr_cnt <= '0;
            end else if (wr_hs) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/shf_top.sv
// ========================================
// Shift engine top, controller, producer,
// buffer and consumer
// ========================================
`timescale 1ns/1ps
`include "shf_settings.svh"

module shf_top import shf_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Job port
    input  logic                   cfg_valid,
    input  shf_job_t               cfg,
    output logic                   cfg_ready,
    // Global buffer read request
    output logic                   rd_req_valid,
    output logic [`SHF_ADDR_W-1:0] rd_addr,
    input  logic                   rd_req_ready,
    // Read return, in request order
    input  logic                   rd_data_valid,
    input  logic [`SHF_DATA_W-1:0] rd_data,
    // Global buffer write
    output logic                   wr_valid,
    output logic [`SHF_ADDR_W-1:0] wr_addr,
    output logic [`SHF_DATA_W-1:0] wr_data,
    input  logic                   wr_ready
);

    // Job distribution
    logic     start;
    shf_job_t job;
    // Status
    logic     rd_done;
    logic     wr_done;
    // Credit returns
    logic     in_credit;
    logic     out_credit;
    // Buffer to consumer
    logic     out_push;
    shf_out_t out_word;

    shf_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg       (cfg),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .cfg_ready (cfg_ready),
        .start     (start),
        .job       (job)
    );

    shf_rd_gen u_rd_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .job          (job),
        .rd_req_ready (rd_req_ready),
        .in_credit    (in_credit),
        .rd_req_valid (rd_req_valid),
        .rd_addr      (rd_addr),
        .rd_done      (rd_done)
    );

    shf_align_buf u_align_buf (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .job           (job),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .out_credit    (out_credit),
        .in_credit     (in_credit),
        .out_push      (out_push),
        .out_word      (out_word)
    );

    shf_wr_gen u_wr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .job        (job),
        .out_push   (out_push),
        .out_word   (out_word),
        .wr_ready   (wr_ready),
        .out_credit (out_credit),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_done    (wr_done)
    );

endmodule

//--- testbench/tb_shf_util.svh
// ========================================
// Xorshift, memory content, value check
// and reference model of one job
// ========================================
`ifndef TB_SHF_UTIL_SVH
`define TB_SHF_UTIL_SVH

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Global buffer content, hashed from the whole address
function automatic logic [31:0] mem_word(input logic [`SHF_ADDR_W-1:0] addr);
    return xorshift32({16'h0, addr} ^ 32'h5a3c96e1);
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

// Expected writes of one job, appended behind any earlier job
// Output byte b of word k is stream byte 4k + off + b, zero past the end
task automatic build_expected(input shf_job_t j);
    int          idx;
    int          stream_len;
    logic [31:0] w;
    logic [31:0] src;
    stream_len = `SHF_BYTES * int'(j.num);
    for (int k = 0; k < int'(j.num); k++) begin
        w = '0;
        for (int b = 0; b < `SHF_BYTES; b++) begin
            idx = k * `SHF_BYTES + int'(j.byte_off) + b;
            if (idx < stream_len) begin
                src = mem_word(j.in_addr + 16'(idx / `SHF_BYTES));
                w[8*b +: 8] = 8'(src >> (8 * (idx % `SHF_BYTES)));
            end
        end
        exp_addr_q.push_back(j.out_addr + 16'(k));
        exp_data_q.push_back(w);
    end
endtask

`endif

//--- testbench/tb_shf_top.sv
// ========================================
// Testbench for the shift engine, global
// buffer model, job tests and report
// ========================================
`timescale 1ns/1ps
`include "shf_settings.svh"

module tb_shf_top import shf_pkg::*;;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_valid;
    shf_job_t               cfg;
    logic                   cfg_ready;
    logic                   rd_req_valid;
    logic [`SHF_ADDR_W-1:0] rd_addr;
    logic                   rd_req_ready;
    logic                   rd_data_valid;
    logic [`SHF_DATA_W-1:0] rd_data;
    logic                   wr_valid;
    logic [`SHF_ADDR_W-1:0] wr_addr;
    logic [`SHF_DATA_W-1:0] wr_data;
    logic                   wr_ready;

    // ========================================
    // Bookkeeping
    // ========================================
    logic [31:0]            rng;
    int                     cycle;
    int                     checks;
    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    // Reads taken and not yet popped from the input queue
    int                     outstanding;
    int                     last_due;
    int                     wr_seen;
    int                     last_wr_cycle;
    int                     cfg_cycle;
    logic [31:0]            last_wr_data;
    // Job waiting to be driven on the job port
    logic                   pend_valid;
    shf_job_t               pend_job;
    logic                   cfg_taken;
    // Ready probabilities in percent
    int                     rd_pct;
    int                     wr_pct;
    logic [`SHF_ADDR_W-1:0] ret_addr_q [$];
    int                     ret_due_q [$];
    logic [`SHF_ADDR_W-1:0] exp_addr_q [$];
    logic [`SHF_DATA_W-1:0] exp_data_q [$];

    `include "tb_shf_util.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    shf_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_valid     (cfg_valid),
        .cfg           (cfg),
        .cfg_ready     (cfg_ready),
        .rd_req_valid  (rd_req_valid),
        .rd_addr       (rd_addr),
        .rd_req_ready  (rd_req_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_ready      (wr_ready)
    );

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic chance(input int pct);
        return int'(next_rand() % 32'd100) < pct;
    endfunction

    // Random job, 1 to 20 words
    function automatic shf_job_t rand_job();
        shf_job_t    j;
        logic [31:0] r;
        r          = next_rand();
        j.in_addr  = r[15:0];
        j.out_addr = r[31:16];
        r          = next_rand();
        j.num      = 8'(1 + int'(r[7:0] % 8'd20));
        j.byte_off = r[9:8];
        return j;
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed + 1, checks, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // ========================================
    // One clock cycle of the memory model
    // ========================================
    // Drive on the falling edge, then look at the settled
    // handshakes that the next rising edge will take
    task automatic step_cycle();
        int due;
        @(negedge clk);
        cycle++;
        cfg_valid = pend_valid;
        cfg       = pend_job;
        // Read return, in order, one word per cycle
        if (ret_due_q.size() != 0 && ret_due_q[0] <= cycle) begin
            rd_data_valid = 1'b1;
            rd_data       = mem_word(ret_addr_q.pop_front());
            void'(ret_due_q.pop_front());
        end else begin
            rd_data_valid = 1'b0;
            rd_data       = next_rand();
        end
        rd_req_ready = chance(rd_pct);
        wr_ready     = chance(wr_pct);
        #1;
        // Buffer pop hands a credit back to the producer
        if (uut.in_credit) begin
            outstanding--;
        end
        if (rd_req_valid && rd_req_ready) begin
            // 1 to 4 cycles of latency, never overtaking
            due = cycle + 1 + int'(next_rand() % 32'd4);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            ret_addr_q.push_back(rd_addr);
            ret_due_q.push_back(due);
            outstanding++;
            if (outstanding > `SHF_IN_DEPTH) begin
                errors++;
                $display("ERROR: %0d reads outstanding, more than the input queue holds",
                         outstanding);
            end
        end
        if (wr_valid && wr_ready) begin
            wr_seen++;
            last_wr_cycle = cycle;
            last_wr_data  = wr_data;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("ERROR: unexpected write to address 0x%04h", wr_addr);
            end else begin
                check_value("wr_addr", 32'(wr_addr), 32'(exp_addr_q.pop_front()));
                check_value("wr_data", wr_data, exp_data_q.pop_front());
            end
        end
        if (cfg_valid && cfg_ready) begin
            cfg_taken  = 1'b1;
            cfg_cycle  = cycle;
            pend_valid = 1'b0;
        end
    endtask

    // ========================================
    // Job helpers
    // ========================================
    task automatic offer_job(input shf_job_t j);
        build_expected(j);
        pend_job   = j;
        pend_valid = 1'b1;
        cfg_taken  = 1'b0;
    endtask

    task automatic wait_accept(input int limit, input string what);
        int n;
        n = 0;
        while (!cfg_taken && n < limit) begin
            step_cycle();
            n++;
        end
        if (!cfg_taken) begin
            abort_run({"timeout waiting for the ", what, " job to be accepted"});
        end
    endtask

    // Done when cfg_ready comes back
    task automatic wait_idle(input int limit, input string what);
        int n;
        n = 0;
        do begin
            step_cycle();
            n++;
        end while (!cfg_ready && n < limit);
        if (!cfg_ready) begin
            abort_run({"timeout waiting for the ", what, " job to finish"});
        end
    endtask

    // Missing writes are whatever the model still expects
    task automatic check_drained();
        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d expected writes never happened", exp_addr_q.size());
            exp_addr_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic run_job(input shf_job_t j);
        int seen;
        seen = wr_seen;
        offer_job(j);
        wait_accept(100, "current");
        wait_idle(4000, "current");
        if (wr_seen - seen != int'(j.num)) begin
            errors++;
            $display("ERROR: job wrote %0d words instead of %0d", wr_seen - seen, j.num);
        end
        check_drained();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // ========================================
    // Tests
    // ========================================
    initial begin
        int       e0;
        int       seen;
        shf_job_t j;
        shf_job_t jb;
        rng           = 32'he8f213e1;
        cycle         = 0;
        checks        = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        outstanding   = 0;
        last_due      = 0;
        wr_seen       = 0;
        last_wr_cycle = 0;
        cfg_cycle     = 0;
        last_wr_data  = '0;
        pend_valid    = 1'b0;
        pend_job      = '0;
        cfg_taken     = 1'b0;
        rd_pct        = 75;
        wr_pct        = 100;
        rst_n         = 1'b0;
        cfg_valid     = 1'b0;
        cfg           = '0;
        rd_req_ready  = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
        wr_ready      = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        step_cycle();
        check_value("cfg_ready", 32'(cfg_ready), 32'd1);
        check_value("rd_req_valid", 32'(rd_req_valid), 32'd0);
        check_value("wr_valid", 32'(wr_valid), 32'd0);
        finish_test("reset state", e0);

        e0         = errors;
        j.in_addr  = 16'h0100;
        j.out_addr = 16'h0800;
        j.num      = 8'd8;
        j.byte_off = 2'd0;
        run_job(j);
        finish_test("plain copy", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            run_job(rand_job());
        end
        finish_test("random realignment", e0);

        // Slow writes back up the whole pipe
        e0     = errors;
        rd_pct = 50;
        wr_pct = 30;
        for (int i = 0; i < 10; i++) begin
            run_job(rand_job());
        end
        finish_test("back-pressure and credits", e0);

        // Second job held on the port while the first runs
        e0          = errors;
        rd_pct      = 75;
        wr_pct      = 100;
        j           = rand_job();
        jb.in_addr  = 16'h4321;
        jb.out_addr = 16'h9000;
        jb.num      = 8'd1;
        jb.byte_off = 2'd3;
        seen        = wr_seen;
        offer_job(j);
        wait_accept(100, "first");
        offer_job(jb);
        wait_accept(4000, "second");
        if (wr_seen - seen != int'(j.num)) begin
            errors++;
            $display("ERROR: second job taken before the first finished its writes");
        end
        if (cfg_cycle != last_wr_cycle + 1) begin
            errors++;
            $display("ERROR: cfg_ready did not return one cycle after the final write");
        end
        wait_idle(4000, "second");
        // Only the lowest byte can carry data
        check_value("wr_data", last_wr_data & 32'hffffff00, 32'h0);
        check_drained();
        finish_test("back-to-back jobs", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
+incdir+testbench
verilog/shf_pkg.sv
verilog/shf_ctrl.sv
verilog/shf_rd_gen.sv
verilog/shf_align_buf.sv
verilog/shf_wr_gen.sv
verilog/shf_top.sv
testbench/tb_shf_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the shift engine testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_shf_top -f vlog.f -o tb_shf_sim \
    && ./obj_dir/tb_shf_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
